//--- common/mips_pkg.sv
// Shared MIPS decode definitions: opcode and funct values, ALU
// operation codes and instruction field positions
`default_nettype none

package mips_pkg;

    // Primary opcodes, instr[31:26]
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_JAL   = 6'h03;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // Funct codes for R-type, instr[5:0]
    localparam logic [5:0] FN_JR  = 6'h08;
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    // Operation requested from the execute stage ALU.
    // ALU_ADD is zero so that a bubble decodes as add
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4,
        ALU_LUI = 4'd5
    } alu_op_t;

    // Low bit of each register field
    localparam int RS_LSB = 21;
    localparam int RT_LSB = 16;
    localparam int RD_LSB = 11;

endpackage

`default_nettype wire

//--- filelist.f
common/mips_pkg.sv
hw/instr_decode/register_file.sv
hw/instr_decode/instr_decode.sv
hw/main_control.sv
hw/forward_unit.sv
hw/id_ex_reg.sv
hw/decode_top.sv
testbench/tb_decode_top.sv

//--- hw/decode_top.sv
// Decode stage top level: datapath, control decoder, branch forwarding
// and the ID/EX register
`timescale 1ns/100ps
`default_nettype none

module decode_top #(
    parameter int INST_SZ = 32,
    parameter int REG_SZ  = 5
) (
    input  wire                 i_clk,
    input  wire                 i_rst_n,
    input  wire  [INST_SZ-1:0]  i_instr,
    input  wire  [INST_SZ-1:0]  i_npc,
    input  wire  [INST_SZ-1:0]  i_alu_result_m,
    input  wire  [REG_SZ-1:0]   i_write_reg_m,
    input  wire                 i_reg_write_m,
    input  wire                 i_reg_write_w,
    input  wire  [REG_SZ-1:0]   i_write_reg_w,
    input  wire  [INST_SZ-1:0]  i_write_data_w,
    input  wire  [REG_SZ-1:0]   i_debug_addr,
    input  wire                 i_stall,
    input  wire                 i_flush,
    output logic [INST_SZ-1:0]  o_debug_data,
    output logic                o_pc_src,
    output logic                o_jump,
    output logic [INST_SZ-1:0]  o_branch_addr,
    output logic [INST_SZ-1:0]  o_jump_addr,
    output logic                o_ex_reg_write,
    output logic                o_ex_mem_read,
    output logic                o_ex_mem_write,
    output logic                o_ex_mem_to_reg,
    output logic                o_ex_alu_src,
    output logic                o_ex_reg_dst,
    output mips_pkg::alu_op_t   o_ex_alu_op,
    output logic [INST_SZ-1:0]  o_ex_read_data_1,
    output logic [INST_SZ-1:0]  o_ex_read_data_2,
    output logic [INST_SZ-1:0]  o_ex_imm,
    output logic [REG_SZ-1:0]   o_ex_rs,
    output logic [REG_SZ-1:0]   o_ex_rt,
    output logic [REG_SZ-1:0]   o_ex_rd
);

    import mips_pkg::*;

    logic               forward_a, forward_b;
    logic               branch, equal;
    logic               reg_write, mem_read, mem_write, mem_to_reg, alu_src, reg_dst;
    alu_op_t            alu_op;
    logic [INST_SZ-1:0] read_data_1, read_data_2, imm;
    logic [REG_SZ-1:0]  rs, rt, rd;

    instr_decode #(.INST_SZ(INST_SZ), .REG_SZ(REG_SZ)) instr_decode_i (
        .i_clk (i_clk), .i_rst_n (i_rst_n),
        .i_instr (i_instr), .i_npc (i_npc),
        .i_forward_a (forward_a), .i_forward_b (forward_b),
        .i_alu_result_m (i_alu_result_m),
        .i_branch (branch), .i_equal (equal), .i_jump (o_jump),
        .i_reg_write_w (i_reg_write_w), .i_write_reg_w (i_write_reg_w),
        .i_write_data_w (i_write_data_w), .i_debug_addr (i_debug_addr),
        .o_debug_data (o_debug_data),
        .o_read_data_1 (read_data_1), .o_read_data_2 (read_data_2),
        .o_imm (imm), .o_rs (rs), .o_rt (rt), .o_rd (rd),
        .o_pc_src (o_pc_src), .o_branch_addr (o_branch_addr), .o_jump_addr (o_jump_addr)
    );

    main_control main_control_i (
        .i_opcode (i_instr[INST_SZ-1 -: 6]), .i_funct (i_instr[5:0]),
        .o_reg_write (reg_write), .o_mem_read (mem_read), .o_mem_write (mem_write),
        .o_mem_to_reg (mem_to_reg), .o_alu_src (alu_src), .o_reg_dst (reg_dst),
        .o_alu_op (alu_op), .o_branch (branch), .o_equal (equal), .o_jump (o_jump)
    );

    forward_unit #(.REG_SZ(REG_SZ)) forward_unit_i (
        .i_rs (rs), .i_rt (rt),
        .i_write_reg_m (i_write_reg_m), .i_reg_write_m (i_reg_write_m),
        .o_forward_a (forward_a), .o_forward_b (forward_b)
    );

    id_ex_reg #(.INST_SZ(INST_SZ), .REG_SZ(REG_SZ)) id_ex_reg_i (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_stall (i_stall), .i_flush (i_flush),
        .i_reg_write (reg_write), .i_mem_read (mem_read), .i_mem_write (mem_write),
        .i_mem_to_reg (mem_to_reg), .i_alu_src (alu_src), .i_reg_dst (reg_dst),
        .i_alu_op (alu_op), .i_read_data_1 (read_data_1), .i_read_data_2 (read_data_2),
        .i_imm (imm), .i_rs (rs), .i_rt (rt), .i_rd (rd),
        .o_reg_write (o_ex_reg_write), .o_mem_read (o_ex_mem_read),
        .o_mem_write (o_ex_mem_write), .o_mem_to_reg (o_ex_mem_to_reg),
        .o_alu_src (o_ex_alu_src), .o_reg_dst (o_ex_reg_dst), .o_alu_op (o_ex_alu_op),
        .o_read_data_1 (o_ex_read_data_1), .o_read_data_2 (o_ex_read_data_2),
        .o_imm (o_ex_imm), .o_rs (o_ex_rs), .o_rt (o_ex_rt), .o_rd (o_ex_rd)
    );

endmodule

`default_nettype wire

//--- hw/forward_unit.sv
// Forwarding select for the decode stage branch comparison
`timescale 1ns/100ps
`default_nettype none

module forward_unit #(
    parameter int REG_SZ = 5
) (
    input  wire  [REG_SZ-1:0]   i_rs,
    input  wire  [REG_SZ-1:0]   i_rt,
    input  wire  [REG_SZ-1:0]   i_write_reg_m,          // Memory stage destination
    input  wire                 i_reg_write_m,
    output logic                o_forward_a,
    output logic                o_forward_b
);

    logic dest_valid;

    // $0 is hardwired, so a match on it must never forward
    assign dest_valid = i_reg_write_m && (i_write_reg_m != '0);

    assign o_forward_a = dest_valid && (i_write_reg_m == i_rs);
    assign o_forward_b = dest_valid && (i_write_reg_m == i_rt);

endmodule

`default_nettype wire

//--- hw/id_ex_reg.sv
// ID/EX pipeline register with stall hold and flush bubble
`timescale 1ns/100ps
`default_nettype none

module id_ex_reg #(
    parameter int INST_SZ = 32,
    parameter int REG_SZ  = 5
) (
    input  wire                 i_clk,
    input  wire                 i_rst_n,
    input  wire                 i_stall,                // Hold current contents
    input  wire                 i_flush,                // Insert bubble, beats stall
    input  wire                 i_reg_write,
    input  wire                 i_mem_read,
    input  wire                 i_mem_write,
    input  wire                 i_mem_to_reg,
    input  wire                 i_alu_src,
    input  wire                 i_reg_dst,
    input  var mips_pkg::alu_op_t i_alu_op,
    input  wire  [INST_SZ-1:0]  i_read_data_1,
    input  wire  [INST_SZ-1:0]  i_read_data_2,
    input  wire  [INST_SZ-1:0]  i_imm,
    input  wire  [REG_SZ-1:0]   i_rs,
    input  wire  [REG_SZ-1:0]   i_rt,
    input  wire  [REG_SZ-1:0]   i_rd,
    output logic                o_reg_write,
    output logic                o_mem_read,
    output logic                o_mem_write,
    output logic                o_mem_to_reg,
    output logic                o_alu_src,
    output logic                o_reg_dst,
    output mips_pkg::alu_op_t   o_alu_op,
    output logic [INST_SZ-1:0]  o_read_data_1,
    output logic [INST_SZ-1:0]  o_read_data_2,
    output logic [INST_SZ-1:0]  o_imm,
    output logic [REG_SZ-1:0]   o_rs,
    output logic [REG_SZ-1:0]   o_rt,
    output logic [REG_SZ-1:0]   o_rd
);

    import mips_pkg::*;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_flush) begin
            o_reg_write   <= 1'b0;   // Bubble, no side effects downstream
            o_mem_read    <= 1'b0;
            o_mem_write   <= 1'b0;
            o_mem_to_reg  <= 1'b0;
            o_alu_src     <= 1'b0;
            o_reg_dst     <= 1'b0;
            o_alu_op      <= ALU_ADD;
            o_read_data_1 <= '0;
            o_read_data_2 <= '0;
            o_imm         <= '0;
            o_rs          <= '0;
            o_rt          <= '0;
            o_rd          <= '0;
        end else if (!i_stall) begin
            o_reg_write   <= i_reg_write;
            o_mem_read    <= i_mem_read;
            o_mem_write   <= i_mem_write;
            o_mem_to_reg  <= i_mem_to_reg;
            o_alu_src     <= i_alu_src;
            o_reg_dst     <= i_reg_dst;
            o_alu_op      <= i_alu_op;
            o_read_data_1 <= i_read_data_1;
            o_read_data_2 <= i_read_data_2;
            o_imm         <= i_imm;
            o_rs          <= i_rs;
            o_rt          <= i_rt;
            o_rd          <= i_rd;
        end
    end

endmodule

`default_nettype wire

//--- hw/instr_decode/instr_decode.sv
// Decode datapath: operand forwarding, equality compare, branch decision,
// sign extension and branch and jump target generation
`timescale 1ns/100ps
`default_nettype none

module instr_decode #(
    parameter int INST_SZ = 32,
    parameter int REG_SZ  = 5
) (
    input  wire                 i_clk,
    input  wire                 i_rst_n,
    input  wire  [INST_SZ-1:0]  i_instr,
    input  wire  [INST_SZ-1:0]  i_npc,                  // PC + 4 of this instruction
    input  wire                 i_forward_a,
    input  wire                 i_forward_b,
    input  wire  [INST_SZ-1:0]  i_alu_result_m,         // Memory stage ALU result
    input  wire                 i_branch,
    input  wire                 i_equal,                // 1 for beq, 0 for bne
    input  wire                 i_jump,
    input  wire                 i_reg_write_w,
    input  wire  [REG_SZ-1:0]   i_write_reg_w,
    input  wire  [INST_SZ-1:0]  i_write_data_w,
    input  wire  [REG_SZ-1:0]   i_debug_addr,
    output logic [INST_SZ-1:0]  o_debug_data,
    output logic [INST_SZ-1:0]  o_read_data_1,
    output logic [INST_SZ-1:0]  o_read_data_2,
    output logic [INST_SZ-1:0]  o_imm,
    output logic [REG_SZ-1:0]   o_rs,
    output logic [REG_SZ-1:0]   o_rt,
    output logic [REG_SZ-1:0]   o_rd,
    output logic                o_pc_src,
    output logic [INST_SZ-1:0]  o_branch_addr,
    output logic [INST_SZ-1:0]  o_jump_addr
);

    import mips_pkg::*;

    logic [INST_SZ-1:0] rf_data_1;
    logic [INST_SZ-1:0] rf_data_2;
    logic               operands_eq;

    assign o_rs = i_instr[RS_LSB +: REG_SZ];
    assign o_rt = i_instr[RT_LSB +: REG_SZ];
    assign o_rd = i_instr[RD_LSB +: REG_SZ];

    register_file #(
        .INST_SZ (INST_SZ),
        .REG_SZ  (REG_SZ)
    ) register_file_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_reg_write   (i_reg_write_w),
        .i_write_reg   (i_write_reg_w),
        .i_write_data  (i_write_data_w),
        .i_read_reg_1  (o_rs),
        .i_read_reg_2  (o_rt),
        .i_debug_addr  (i_debug_addr),
        .o_read_data_1 (rf_data_1),
        .o_read_data_2 (rf_data_2),
        .o_debug_data  (o_debug_data)
    );

    // Early operands, possibly taken from the memory stage
    assign o_read_data_1 = i_forward_a ? i_alu_result_m : rf_data_1;
    assign o_read_data_2 = i_forward_b ? i_alu_result_m : rf_data_2;

    assign operands_eq = (o_read_data_1 == o_read_data_2);

    // Taken when the compare agrees with beq/bne; a jump overrides it
    assign o_pc_src = i_branch && !i_jump && (operands_eq == i_equal);

    assign o_imm = {{(INST_SZ-16){i_instr[15]}}, i_instr[15:0]};

    assign o_branch_addr = i_npc + (o_imm << 2);
    assign o_jump_addr   = {i_npc[INST_SZ-1 -: 4], i_instr[25:0], 2'b00};   // Pseudo-direct

endmodule

`default_nettype wire

//--- hw/instr_decode/register_file.sv
// General purpose register file with two read ports, one write port,
// a debug read port and write-through bypass
`timescale 1ns/100ps
`default_nettype none

module register_file #(
    parameter int INST_SZ = 32,
    parameter int REG_SZ  = 5
) (
    input  wire                 i_clk,
    input  wire                 i_rst_n,
    input  wire                 i_reg_write,            // Writeback enable
    input  wire  [REG_SZ-1:0]   i_write_reg,
    input  wire  [INST_SZ-1:0]  i_write_data,
    input  wire  [REG_SZ-1:0]   i_read_reg_1,
    input  wire  [REG_SZ-1:0]   i_read_reg_2,
    input  wire  [REG_SZ-1:0]   i_debug_addr,
    output logic [INST_SZ-1:0]  o_read_data_1,
    output logic [INST_SZ-1:0]  o_read_data_2,
    output logic [INST_SZ-1:0]  o_debug_data
);

    localparam int DEPTH = 2 ** REG_SZ;

    logic [INST_SZ-1:0] regs [DEPTH];
    logic               wr_en;                          // Qualified write, never to $0

    assign wr_en = i_reg_write && (i_write_reg != '0);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[i_write_reg] <= i_write_data;
        end
    end

    // Writeback in the same cycle wins over the stored value
    assign o_read_data_1 = (wr_en && (i_read_reg_1 == i_write_reg)) ? i_write_data
                                                                     : regs[i_read_reg_1];
    assign o_read_data_2 = (wr_en && (i_read_reg_2 == i_write_reg)) ? i_write_data
                                                                     : regs[i_read_reg_2];

    assign o_debug_data = regs[i_debug_addr];                // Stored contents only

endmodule

`default_nettype wire

//--- hw/main_control.sv
// Main control decoder from opcode and funct to pipeline control lines
`timescale 1ns/100ps
`default_nettype none

module main_control (
    input  wire  [5:0]          i_opcode,
    input  wire  [5:0]          i_funct,
    output logic                o_reg_write,
    output logic                o_mem_read,
    output logic                o_mem_write,
    output logic                o_mem_to_reg,
    output logic                o_alu_src,              // Immediate as second operand
    output logic                o_reg_dst,              // Destination is rd, else rt
    output mips_pkg::alu_op_t   o_alu_op,
    output logic                o_branch,
    output logic                o_equal,
    output logic                o_jump
);

    import mips_pkg::*;

    always_comb begin
        o_reg_write  = 1'b0;
        o_mem_read   = 1'b0;
        o_mem_write  = 1'b0;
        o_mem_to_reg = 1'b0;
        o_alu_src    = 1'b0;
        o_reg_dst    = 1'b0;
        o_alu_op     = ALU_ADD;
        o_branch     = 1'b0;
        o_equal      = 1'b0;
        o_jump       = 1'b0;

        case (i_opcode)
            OP_RTYPE: begin
                o_reg_dst   = 1'b1;
                o_reg_write = 1'b1;
                case (i_funct)
                    FN_ADD: o_alu_op = ALU_ADD;
                    FN_SUB: o_alu_op = ALU_SUB;
                    FN_AND: o_alu_op = ALU_AND;
                    FN_OR:  o_alu_op = ALU_OR;
                    FN_SLT: o_alu_op = ALU_SLT;
                    FN_JR: begin
                        o_reg_write = 1'b0;   // Register jump writes nothing
                        o_reg_dst   = 1'b0;
                    end
                    default: begin
                        o_reg_write = 1'b0;   // Unknown funct
                        o_reg_dst   = 1'b0;
                    end
                endcase
            end
            OP_LW: begin
                o_reg_write  = 1'b1;
                o_mem_read   = 1'b1;
                o_mem_to_reg = 1'b1;
                o_alu_src    = 1'b1;
            end
            OP_SW: begin
                o_mem_write = 1'b1;
                o_alu_src   = 1'b1;
            end
            OP_ADDI: begin
                o_reg_write = 1'b1;
                o_alu_src   = 1'b1;
            end
            OP_ANDI: begin
                o_reg_write = 1'b1;
                o_alu_src   = 1'b1;
                o_alu_op    = ALU_AND;
            end
            OP_ORI: begin
                o_reg_write = 1'b1;
                o_alu_src   = 1'b1;
                o_alu_op    = ALU_OR;
            end
            OP_SLTI: begin
                o_reg_write = 1'b1;
                o_alu_src   = 1'b1;
                o_alu_op    = ALU_SLT;
            end
            OP_LUI: begin
                o_reg_write = 1'b1;
                o_alu_src   = 1'b1;
                o_alu_op    = ALU_LUI;
            end
            OP_BEQ: begin
                o_branch = 1'b1;
                o_equal  = 1'b1;
                o_alu_op = ALU_SUB;
            end
            OP_BNE: begin
                o_branch = 1'b1;
                o_alu_op = ALU_SUB;
            end
            OP_J, OP_JAL: o_jump = 1'b1;   // Link write for jal is handled downstream
            default: ;                     // All controls stay low
        endcase
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the decode stage testbench; the exit status follows the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_decode_top -f filelist.f -o tb_decode_top \
    || { echo "Verilator build failed"; exit 1; }
result=$(./obj_dir/tb_decode_top)
echo "$result"
echo "$result" | grep -qx "test passed" && exit 0 || exit 1

//--- testbench/decode_cases.txt
# In: instr npc alu_result_m {reg_write_m,write_reg_m} {reg_write_w,write_reg_w} write_data_w
#     debug_addr {stall,flush}   Out: debug_data {pc_src,jump} branch_addr jump_addr ctrl
#     read_data_1 read_data_2 imm {rs,rt,rd}, all hex
# ctrl is {reg_write,mem_read,mem_write,mem_to_reg,alu_src,reg_dst,alu_op[3:0]}
# Writeback writes read back on the debug port, $0 stays zero
00000000 0 0 0 21 11111111 1 0  11111111 0 0 0 0 0 0 0 0
00000000 0 0 0 22 22222222 2 0  22222222 0 0 0 0 0 0 0 0
00000000 0 0 0 23 11111111 3 0  11111111 0 0 0 0 0 0 0 0
00000000 0 0 0 20 deadbeef 0 0  0 0 0 0 0 0 0 0 0
00000000 0 0 0 3f 80000000 1f 0  80000000 0 0 0 0 0 0 0 0
00000000 0 0 0 0 0 2 0  22222222 0 0 0 0 0 0 0 0
# addi with positive and negative immediates, branch targets
20240010 400004 0 0 0 0 0 0  0 0 400044 900040 220 11111111 0 10 480
2045fff0 400100 0 0 0 0 0 0  0 0 4000c0 117ffc0 220 22222222 0 fffffff0 8bf
23e68000 10000000 0 0 0 0 0 0  0 0 ffe0000 1f9a0000 220 80000000 0 ffff8000 7cd0
# j and jal
08123456 a0000008 0 0 0 0 0 0  0 1 a000d160 a048d158 0 0 0 3456 246
0fffffff 50000000 0 0 0 0 0 0  0 1 4ffffffc 5ffffffc 0 80000000 80000000 ffffffff 7fff
# beq and bne with equal and unequal operands
10230004 400010 0 0 0 0 0 0  0 2 400020 8c0010 1 11111111 11111111 4 460
10220004 400010 0 0 0 0 0 0  0 0 400020 880010 1 11111111 22222222 4 440
1422fffe 400020 0 0 0 0 0 0  0 2 400018 8bfff8 1 11111111 22222222 fffffffe 45f
1423fffe 400020 0 0 0 0 0 0  0 0 400018 8ffff8 1 11111111 11111111 fffffffe 47f
# Memory stage forwarding, disabled write, and $0 that must not forward
10220004 400010 11111111 22 0 0 0 0  0 2 400020 880010 1 11111111 11111111 4 440
1423fffe 400020 12345678 21 0 0 0 0  0 2 400018 8ffff8 1 12345678 11111111 fffffffe 47f
10220004 400010 11111111 2 0 0 0 0  0 0 400020 880010 1 11111111 22222222 4 440
10200004 400010 11111111 20 0 0 0 0  0 0 400020 800010 1 11111111 0 4 400
# Write-through bypass feeding beq
10240004 400010 0 0 24 11111111 4 0  11111111 2 400020 900010 1 11111111 11111111 4 480
# add, sub, lw, sw, lui, then stall, flush and flush with stall
00223820 400030 0 0 0 0 0 0  0 0 40e0b0 88e080 210 11111111 22222222 3820 447
00414022 400034 0 0 0 0 0 0  0 0 4100bc 1050088 211 22222222 11111111 4022 828
8c290008 400038 0 0 0 0 0 0  0 0 400058 a40020 360 11111111 0 8 520
ac62fffc 40003c 0 0 0 0 0 0  0 0 40002c 18bfff0 a0 11111111 22222222 fffffffc c5f
3c0a1234 400040 0 0 0 0 0 0  0 0 404910 2848d0 225 0 0 1234 142
20240010 400004 0 0 0 0 0 2  0 0 400044 900040 225 0 0 1234 142
20240010 400004 0 0 0 0 0 1  0 0 400044 900040 0 0 0 0 0
20240010 400004 0 0 0 0 4 0  11111111 0 400044 900040 220 11111111 11111111 10 480
20240010 400004 0 0 0 0 0 3  0 0 400044 900040 0 0 0 0 0
00000000 0 0 0 0 0 1f 0  80000000 0 0 0 0 0 0 0 0

//--- testbench/tb_decode_top.sv
// Decode stage testbench that replays the case file on the DUT and
// checks the branch and jump outputs, the debug port and the ID/EX outputs
`timescale 1ns/100ps
`default_nettype none

module tb_decode_top;

    localparam int MAX_CASES = 64;
    localparam int N_FIELDS  = 17;

    // Columns of the case file
    localparam int C_INSTR = 0,  C_NPC = 1,   C_ALU_M = 2,  C_MEM_WR = 3,  C_WB = 4;
    localparam int C_WDATA = 5,  C_DBG = 6,   C_SF = 7,     C_DBG_DATA = 8, C_BR = 9;
    localparam int C_BADDR = 10, C_JADDR = 11, C_CTRL = 12, C_RD1 = 13,    C_RD2 = 14;
    localparam int C_IMM = 15,   C_REGS = 16;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] instr, npc, alu_result_m, write_data_w;
    logic [4:0]  write_reg_m, write_reg_w, debug_addr;
    logic        reg_write_m, reg_write_w, stall, flush;

    logic [31:0] debug_data, branch_addr, jump_addr;
    logic        pc_src, jump;
    logic        ex_reg_write, ex_mem_read, ex_mem_write, ex_mem_to_reg, ex_alu_src, ex_reg_dst;
    logic [3:0]  ex_alu_op;
    logic [31:0] ex_read_data_1, ex_read_data_2, ex_imm;
    logic [4:0]  ex_rs, ex_rt, ex_rd;

    logic [31:0] cases [MAX_CASES][N_FIELDS];
    int          num_cases = 0;
    int          case_idx = -1;                     // -1 while checking the reset state
    int          checks = 0;
    int          errors = 0;
    int          cycle_count = 0;
    int          cycle_limit = 20;

    decode_top #(.INST_SZ(32), .REG_SZ(5)) decode_top_i (
        .i_clk (clk), .i_rst_n (rst_n), .i_instr (instr), .i_npc (npc),
        .i_alu_result_m (alu_result_m), .i_write_reg_m (write_reg_m),
        .i_reg_write_m (reg_write_m), .i_reg_write_w (reg_write_w),
        .i_write_reg_w (write_reg_w), .i_write_data_w (write_data_w),
        .i_debug_addr (debug_addr), .i_stall (stall), .i_flush (flush),
        .o_debug_data (debug_data), .o_pc_src (pc_src), .o_jump (jump),
        .o_branch_addr (branch_addr), .o_jump_addr (jump_addr),
        .o_ex_reg_write (ex_reg_write), .o_ex_mem_read (ex_mem_read),
        .o_ex_mem_write (ex_mem_write), .o_ex_mem_to_reg (ex_mem_to_reg),
        .o_ex_alu_src (ex_alu_src), .o_ex_reg_dst (ex_reg_dst), .o_ex_alu_op (ex_alu_op),
        .o_ex_read_data_1 (ex_read_data_1), .o_ex_read_data_2 (ex_read_data_2),
        .o_ex_imm (ex_imm), .o_ex_rs (ex_rs), .o_ex_rt (ex_rt), .o_ex_rd (ex_rd)
    );

    always #2 clk = ~clk;                           // 4 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("test failed");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        begin
            checks++;
            if (actual !== expected) begin
                errors++;
                $display("MISMATCH %s case %0d: got %h expected %h", name, case_idx,
                         actual, expected);
            end
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [31:0] fld [N_FIELDS];
        begin
            fd = $fopen("testbench/decode_cases.txt", "r");
            if (fd == 0) begin
                $display("Could not open the case file testbench/decode_cases.txt");
            end else begin
                while (!$feof(fd) && num_cases < MAX_CASES) begin
                    n = $fgets(line, fd);
                    if (n > 1 && line.getc(0) != "#") begin
                        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                    fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                                    fld[7], fld[8], fld[9], fld[10], fld[11], fld[12],
                                    fld[13], fld[14], fld[15], fld[16]);
                        if (n == N_FIELDS) begin
                            for (int k = 0; k < N_FIELDS; k++) begin
                                cases[num_cases][k] = fld[k];
                            end
                            num_cases++;
                        end else begin
                            errors++;
                            $display("A case line holds %0d fields instead of %0d", n, N_FIELDS);
                        end
                    end
                end
                $fclose(fd);
            end
        end
    endtask

    task automatic apply_case(input int idx);
        begin
            instr        = cases[idx][C_INSTR];
            npc          = cases[idx][C_NPC];
            alu_result_m = cases[idx][C_ALU_M];
            reg_write_m  = cases[idx][C_MEM_WR][5];    // Enable above the register number
            write_reg_m  = cases[idx][C_MEM_WR][4:0];
            reg_write_w  = cases[idx][C_WB][5];
            write_reg_w  = cases[idx][C_WB][4:0];
            write_data_w = cases[idx][C_WDATA];
            debug_addr   = cases[idx][C_DBG][4:0];
            stall        = cases[idx][C_SF][1];
            flush        = cases[idx][C_SF][0];
        end
    endtask

    // Sampled on the falling edge after the case's rising edge, so the debug
    // port and the ID/EX outputs already reflect this case
    task automatic verify_case(input int idx);
        logic [31:0] ctrl;
        logic [31:0] regs;
        begin
            ctrl     = cases[idx][C_CTRL];
            regs     = cases[idx][C_REGS];
            case_idx = idx;
            compare_value("o_debug_data", debug_data, cases[idx][C_DBG_DATA]);
            compare_value("o_pc_src", 32'(pc_src), 32'(cases[idx][C_BR][1]));
            compare_value("o_jump", 32'(jump), 32'(cases[idx][C_BR][0]));
            compare_value("o_branch_addr", branch_addr, cases[idx][C_BADDR]);
            compare_value("o_jump_addr", jump_addr, cases[idx][C_JADDR]);
            compare_value("o_ex_reg_write", 32'(ex_reg_write), 32'(ctrl[9]));
            compare_value("o_ex_mem_read", 32'(ex_mem_read), 32'(ctrl[8]));
            compare_value("o_ex_mem_write", 32'(ex_mem_write), 32'(ctrl[7]));
            compare_value("o_ex_mem_to_reg", 32'(ex_mem_to_reg), 32'(ctrl[6]));
            compare_value("o_ex_alu_src", 32'(ex_alu_src), 32'(ctrl[5]));
            compare_value("o_ex_reg_dst", 32'(ex_reg_dst), 32'(ctrl[4]));
            compare_value("o_ex_alu_op", 32'(ex_alu_op), 32'(ctrl[3:0]));
            compare_value("o_ex_read_data_1", ex_read_data_1, cases[idx][C_RD1]);
            compare_value("o_ex_read_data_2", ex_read_data_2, cases[idx][C_RD2]);
            compare_value("o_ex_imm", ex_imm, cases[idx][C_IMM]);
            compare_value("o_ex_rs", 32'(ex_rs), 32'(regs[14:10]));
            compare_value("o_ex_rt", 32'(ex_rt), 32'(regs[9:5]));
            compare_value("o_ex_rd", 32'(ex_rd), 32'(regs[4:0]));
        end
    endtask

    task automatic after_reset_check();
        begin
            compare_value("o_debug_data", debug_data, 32'h0);
            compare_value("o_ex_controls", 32'({ex_reg_write, ex_mem_read, ex_mem_write,
                          ex_mem_to_reg, ex_alu_src, ex_reg_dst, ex_alu_op}), 32'h0);
            compare_value("o_ex_read_data_1", ex_read_data_1, 32'h0);
            compare_value("o_ex_imm", ex_imm, 32'h0);
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        instr        = 32'h8fe9_0008;               // lw from $31, masked while in reset
        npc          = '0;
        alu_result_m = '0;
        write_reg_m  = '0;
        reg_write_m  = 1'b0;
        reg_write_w  = 1'b1;                        // Write to $31 that reset holds off
        write_reg_w  = 5'd31;
        write_data_w = 32'h5a5a_5a5a;
        debug_addr   = 5'd31;                       // Any register reads zero after reset
        stall        = 1'b0;
        flush        = 1'b0;
        load_cases();
        cycle_limit = num_cases * 4 + 20;
        if (num_cases == 0) begin
            $display("No usable cases were read, nothing to run");
            $display("test failed");
            $finish;
        end else begin
            repeat (2) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            after_reset_check();
            for (int i = 0; i < num_cases; i++) begin
                apply_case(i);
                @(negedge clk);
                verify_case(i);
            end
            $display("Cases: %0d, checks: %0d, errors: %0d", num_cases, checks, errors);
            if (errors == 0) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire
